/* hdl/panda_pkg.sv */
//====================
// Core package
// Widths and register index types
// Opcode and func encodings
// Status enum shared by decode and ROB
//====================
package panda_pkg;

	localparam int DATA_W   = 64;
	localparam int AR_COUNT = 32;
	localparam int ZERO_REG = 31;	// Reads zero, writes dropped

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [4:0]        ar_idx_t;
	typedef logic [5:0]        pr_idx_t;	// Up to 64 physical registers
	typedef logic [3:0]        rob_idx_t;	// Up to 16 ROB slots
	typedef logic [31:0]       inst_word_t;
	typedef logic [6:0]        func_t;

	// Opcodes
	localparam logic [5:0] OP_HALT = 6'h00;
	localparam logic [5:0] OP_INT  = 6'h10;
	localparam logic [5:0] OP_MUL  = 6'h13;

	// Integer ops under OP_INT
	localparam func_t FUNC_ADD = 7'h20;
	localparam func_t FUNC_SUB = 7'h29;
	localparam func_t FUNC_AND = 7'h00;
	localparam func_t FUNC_OR  = 7'h08;
	localparam func_t FUNC_XOR = 7'h40;
	localparam func_t FUNC_SLL = 7'h39;

	// Only valid func under OP_MUL
	localparam func_t FUNC_MULQ = 7'h20;

	// Also tags each ROB entry as ordinary, halt or illegal
	typedef enum logic [1:0] {
		running,
		halted,
		illegal_inst
	} status_t;

endpackage

/* hdl/inst_decode.sv */
//====================
// Decode and rename stage
// Field split and illegal detection
// Map table and circular free list
// Dispatch stall
//====================
`timescale 1ns/10ps

module inst_decode #(
	parameter int PR_COUNT  = 64,
	parameter int ROB_DEPTH = 16
) (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  inst_valid,
	input  panda_pkg::inst_word_t inst,
	input  logic                  rob_full,
	input  panda_pkg::rob_idx_t   rob_tail,
	input  logic                  issue_busy,
	input  logic                  retire_free,
	input  panda_pkg::pr_idx_t    retire_told,
	output logic                  stall,
	output logic                  disp_valid,
	output panda_pkg::func_t      disp_func,
	output logic                  disp_is_mul,
	output panda_pkg::pr_idx_t    disp_src_a,
	output panda_pkg::pr_idx_t    disp_src_b,
	output logic                  disp_use_lit,
	output panda_pkg::data_t      disp_lit,
	output panda_pkg::pr_idx_t    disp_dest_pr,
	output panda_pkg::ar_idx_t    disp_dest_ar,
	output panda_pkg::pr_idx_t    disp_told,
	output panda_pkg::rob_idx_t   disp_rob_idx,
	output panda_pkg::status_t    disp_kind
);
	import panda_pkg::*;

	localparam int FL_DEPTH = PR_COUNT - AR_COUNT;
	localparam int FL_PW    = $clog2(FL_DEPTH);

	logic [5:0]       opcode;
	ar_idx_t          ra;
	ar_idx_t          rb;
	pr_idx_t          map_tbl [AR_COUNT];
	pr_idx_t          fl_mem [FL_DEPTH];
	logic [FL_PW-1:0] fl_head;
	logic [FL_PW-1:0] fl_tail;
	logic [FL_PW:0]   fl_count;
	logic             fl_pop;
	logic             stopped;	// Halt or illegal already taken

	function automatic logic [FL_PW-1:0] fl_next(input logic [FL_PW-1:0] ptr);
		return (ptr == FL_PW'(FL_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign opcode       = inst[31:26];
	assign ra           = inst[25:21];
	assign rb           = inst[20:16];
	assign disp_lit     = data_t'(inst[20:13]);
	assign disp_use_lit = inst[12];
	assign disp_func    = inst[11:5];
	assign disp_dest_ar = inst[4:0];
	assign disp_is_mul  = (opcode == OP_MUL);

	always_comb begin
		disp_kind = illegal_inst;
		if (opcode == OP_HALT)
			disp_kind = halted;
		else if (opcode == OP_INT && disp_func inside
				{FUNC_ADD, FUNC_SUB, FUNC_AND, FUNC_OR, FUNC_XOR, FUNC_SLL})
			disp_kind = running;
		else if (opcode == OP_MUL && disp_func == FUNC_MULQ)
			disp_kind = running;
	end

	assign stall      = rob_full || fl_count == '0 || issue_busy || stopped;
	assign disp_valid = inst_valid && !stall;
	assign fl_pop     = disp_valid && disp_kind == running;

	// Rename
	assign disp_src_a   = map_tbl[ra];
	assign disp_src_b   = map_tbl[rb];
	assign disp_dest_pr = fl_mem[fl_head];
	assign disp_rob_idx = rob_tail;

	// A write to r31 gets a scratch tag that goes straight back at retire
	assign disp_told = (disp_dest_ar == ZERO_REG) ? disp_dest_pr : map_tbl[disp_dest_ar];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < AR_COUNT; i++)
				map_tbl[i] <= pr_idx_t'(i);
			for (int i = 0; i < FL_DEPTH; i++)
				fl_mem[i] <= pr_idx_t'(AR_COUNT + i);
			fl_head  <= '0;
			fl_tail  <= '0;	// Tail meets head when full
			fl_count <= FL_DEPTH[FL_PW:0];
			stopped  <= 1'b0;
		end else begin
			if (fl_pop && disp_dest_ar != ZERO_REG)
				map_tbl[disp_dest_ar] <= disp_dest_pr;
			if (fl_pop)
				fl_head <= fl_next(fl_head);
			if (retire_free) begin
				fl_mem[fl_tail] <= retire_told;
				fl_tail         <= fl_next(fl_tail);
			end
			fl_count <= fl_count + retire_free - fl_pop;
			if (disp_valid && disp_kind != running)
				stopped <= 1'b1;
		end
	end

	// Head on tail at a pop only when every free tag is still stored
	a_fl_pop: assert property (@(posedge clock) disable iff (!rst_n)
		fl_pop |-> fl_head != fl_tail || fl_count == FL_DEPTH[FL_PW:0]);

	// ROB pointer stays inside the configured depth
	a_rob_tail: assert property (@(posedge clock) disable iff (!rst_n)
		disp_valid |-> rob_tail < ROB_DEPTH);

endmodule

/* hdl/exec_unit.sv */
//====================
// Execute stage
// Single issue slot waiting on operands
// One-cycle ALU on CDB lane 0
// Three-stage multiplier on CDB lane 1
//====================
`timescale 1ns/10ps

module exec_unit #(
	parameter int PR_COUNT = 64
) (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                disp_valid,
	input  panda_pkg::func_t    disp_func,
	input  logic                disp_is_mul,
	input  panda_pkg::pr_idx_t  disp_src_a,
	input  panda_pkg::pr_idx_t  disp_src_b,
	input  logic                disp_use_lit,
	input  panda_pkg::data_t    disp_lit,
	input  panda_pkg::pr_idx_t  disp_dest_pr,
	input  panda_pkg::rob_idx_t disp_rob_idx,
	input  panda_pkg::status_t  disp_kind,
	input  logic                src_a_ready,
	input  logic                src_b_ready,
	input  panda_pkg::data_t    src_a_val,
	input  panda_pkg::data_t    src_b_val,
	output logic                issue_busy,
	output panda_pkg::pr_idx_t  rd_a,
	output panda_pkg::pr_idx_t  rd_b,
	output logic                cdb0_valid,
	output panda_pkg::pr_idx_t  cdb0_tag,
	output panda_pkg::rob_idx_t cdb0_rob,
	output panda_pkg::data_t    cdb0_val,
	output logic                cdb1_valid,
	output panda_pkg::pr_idx_t  cdb1_tag,
	output panda_pkg::rob_idx_t cdb1_rob,
	output panda_pkg::data_t    cdb1_val
);
	import panda_pkg::*;

	logic     slot_valid;
	logic     slot_load;
	logic     slot_is_mul;
	logic     slot_use_lit;
	func_t    slot_func;
	pr_idx_t  slot_dest;
	rob_idx_t slot_rob;
	data_t    slot_lit;
	logic     issue;
	data_t    op_b;
	data_t    alu_res;
	logic [2:0]  mul_v;
	pr_idx_t     mul_tag [3];
	rob_idx_t    mul_rob [3];
	logic [63:0] mul_ll;	// Low halves product
	logic [31:0] mul_x;	// Cross terms, upper word only
	data_t       mul_sum;

	// Halt and illegal entries never enter the slot
	assign slot_load  = disp_valid && disp_kind == running;
	assign issue      = slot_valid && src_a_ready && (slot_use_lit || src_b_ready);
	assign issue_busy = slot_valid && !issue;
	assign op_b       = slot_use_lit ? slot_lit : src_b_val;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			slot_valid <= 1'b0;
		else if (slot_load)
			slot_valid <= 1'b1;
		else if (issue)
			slot_valid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (slot_load) begin
			slot_func    <= disp_func;
			slot_is_mul  <= disp_is_mul;
			rd_a         <= disp_src_a;
			rd_b         <= disp_src_b;
			slot_use_lit <= disp_use_lit;
			slot_lit     <= disp_lit;
			slot_dest    <= disp_dest_pr;
			slot_rob     <= disp_rob_idx;
		end
	end

	always_comb begin
		case (slot_func)
			FUNC_ADD: alu_res = src_a_val + op_b;
			FUNC_SUB: alu_res = src_a_val - op_b;
			FUNC_AND: alu_res = src_a_val & op_b;
			FUNC_OR:  alu_res = src_a_val | op_b;
			FUNC_XOR: alu_res = src_a_val ^ op_b;
			FUNC_SLL: alu_res = src_a_val << op_b[5:0];
			default:  alu_res = '0;
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			cdb0_valid <= 1'b0;
			mul_v      <= '0;
		end else begin
			cdb0_valid <= issue && !slot_is_mul;
			mul_v      <= {mul_v[1:0], issue && slot_is_mul};
		end
	end

	always_ff @(posedge clock) begin
		cdb0_tag   <= slot_dest;
		cdb0_rob   <= slot_rob;
		cdb0_val   <= alu_res;
		mul_tag[0] <= slot_dest;
		mul_rob[0] <= slot_rob;
		mul_ll     <= src_a_val[31:0] * op_b[31:0];
		mul_x      <= src_a_val[63:32] * op_b[31:0] + src_a_val[31:0] * op_b[63:32];
		mul_tag[1] <= mul_tag[0];
		mul_rob[1] <= mul_rob[0];
		mul_sum    <= mul_ll + {mul_x, 32'h0};
		mul_tag[2] <= mul_tag[1];
		mul_rob[2] <= mul_rob[1];
		cdb1_val   <= mul_sum;
	end

	assign cdb1_valid = mul_v[2];
	assign cdb1_tag   = mul_tag[2];
	assign cdb1_rob   = mul_rob[2];

	// Renaming keeps in-flight destinations distinct
	a_cdb_tags: assert property (@(posedge clock) disable iff (!rst_n)
		cdb0_valid && cdb1_valid |-> cdb0_tag != cdb1_tag);

	a_cdb_range: assert property (@(posedge clock) disable iff (!rst_n)
		(!cdb0_valid || cdb0_tag < PR_COUNT) && (!cdb1_valid || cdb1_tag < PR_COUNT));

endmodule

/* hdl/phys_regfile.sv */
//====================
// Physical register file
// Values and ready bits
// Two CDB write lanes, no bypass
//====================
`timescale 1ns/10ps

module phys_regfile #(
	parameter int PR_COUNT = 64
) (
	input  logic               clock,
	input  logic               rst_n,
	input  panda_pkg::pr_idx_t rd_a,
	input  panda_pkg::pr_idx_t rd_b,
	input  logic               alloc_valid,
	input  panda_pkg::pr_idx_t alloc_tag,
	input  logic               cdb0_valid,
	input  panda_pkg::pr_idx_t cdb0_tag,
	input  panda_pkg::data_t   cdb0_val,
	input  logic               cdb1_valid,
	input  panda_pkg::pr_idx_t cdb1_tag,
	input  panda_pkg::data_t   cdb1_val,
	output panda_pkg::data_t   src_a_val,
	output panda_pkg::data_t   src_b_val,
	output logic               src_a_ready,
	output logic               src_b_ready
);
	import panda_pkg::*;

	data_t               regs [PR_COUNT];
	logic [PR_COUNT-1:0] ready;

	assign src_a_val   = regs[rd_a];
	assign src_b_val   = regs[rd_b];
	assign src_a_ready = ready[rd_a];
	assign src_b_ready = ready[rd_b];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < PR_COUNT; i++)
				regs[i] <= '0;	// Architectural state starts at zero
			ready <= '1;
		end else begin
			if (cdb0_valid) begin
				regs[cdb0_tag]  <= cdb0_val;
				ready[cdb0_tag] <= 1'b1;
			end
			if (cdb1_valid) begin
				regs[cdb1_tag]  <= cdb1_val;
				ready[cdb1_tag] <= 1'b1;
			end
			if (alloc_valid)
				ready[alloc_tag] <= 1'b0;	// New producer pending
		end
	end

endmodule

/* hdl/reorder_buffer.sv */
//====================
// Reorder buffer
// In-order retirement and commit port
// Free-list return of the old tag
// Halt and illegal status
//====================
`timescale 1ns/10ps

module reorder_buffer #(
	parameter int ROB_DEPTH = 16
) (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                disp_valid,
	input  panda_pkg::ar_idx_t  disp_dest_ar,
	input  panda_pkg::pr_idx_t  disp_told,
	input  panda_pkg::status_t  disp_kind,
	input  logic                cdb0_valid,
	input  panda_pkg::rob_idx_t cdb0_rob,
	input  panda_pkg::data_t    cdb0_val,
	input  logic                cdb1_valid,
	input  panda_pkg::rob_idx_t cdb1_rob,
	input  panda_pkg::data_t    cdb1_val,
	output logic                rob_full,
	output panda_pkg::rob_idx_t rob_tail,
	output logic                retire_free,
	output panda_pkg::pr_idx_t  retire_told,
	output logic                commit_en,
	output panda_pkg::ar_idx_t  commit_ar_idx,
	output panda_pkg::data_t    commit_data,
	output panda_pkg::status_t  status
);
	import panda_pkg::*;

	localparam int CW = $clog2(ROB_DEPTH + 1);

	logic [ROB_DEPTH-1:0] done;
	status_t  kind [ROB_DEPTH];
	ar_idx_t  dest_ar [ROB_DEPTH];
	pr_idx_t  told [ROB_DEPTH];
	data_t    value [ROB_DEPTH];
	rob_idx_t head;
	logic [CW-1:0] count;
	logic     head_ready;
	logic     retire;

	function automatic rob_idx_t rob_next(input rob_idx_t ptr);
		return (ptr == rob_idx_t'(ROB_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign rob_full   = (count == CW'(ROB_DEPTH));
	assign head_ready = count != '0 && done[head] && status == running;
	assign retire     = head_ready && kind[head] == running;

	assign commit_en     = retire;
	assign commit_ar_idx = dest_ar[head];
	assign commit_data   = value[head];
	assign retire_free   = retire;
	assign retire_told   = told[head];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			head     <= '0;
			rob_tail <= '0;
			count    <= '0;
			done     <= '0;
			status   <= running;
		end else begin
			if (cdb0_valid)
				done[cdb0_rob] <= 1'b1;
			if (cdb1_valid)
				done[cdb1_rob] <= 1'b1;
			if (disp_valid) begin
				done[rob_tail] <= (disp_kind != running);	// Halt, illegal done at once
				rob_tail       <= rob_next(rob_tail);
			end
			if (retire)
				head <= rob_next(head);
			else if (head_ready)
				status <= kind[head];	// Retirement stops here
			count <= count + disp_valid - retire;
		end
	end

	always_ff @(posedge clock) begin
		if (disp_valid) begin
			kind[rob_tail]    <= disp_kind;
			dest_ar[rob_tail] <= disp_dest_ar;
			told[rob_tail]    <= disp_told;
		end
		if (cdb0_valid)
			value[cdb0_rob] <= cdb0_val;
		if (cdb1_valid)
			value[cdb1_rob] <= cdb1_val;
	end

	// Decode must hold dispatch while the ROB is full
	a_no_write_full: assert property (@(posedge clock) disable iff (!rst_n)
		disp_valid |-> !rob_full);

endmodule

/* hdl/panda_core.sv */
//====================
// Core top level
// Decode, execute, register file and ROB
//====================
`timescale 1ns/10ps

module panda_core #(
	parameter int PR_COUNT  = 64,
	parameter int ROB_DEPTH = 16
) (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  inst_valid,
	input  panda_pkg::inst_word_t inst,
	output logic                  stall,
	output logic                  commit_en,
	output panda_pkg::ar_idx_t    commit_ar_idx,
	output panda_pkg::data_t      commit_data,
	output panda_pkg::status_t    status
);
	import panda_pkg::*;

	// Decode to execute and ROB
	logic     disp_valid;
	func_t    disp_func;
	logic     disp_is_mul;
	logic     disp_use_lit;
	data_t    disp_lit;
	pr_idx_t  disp_src_a, disp_src_b;
	pr_idx_t  disp_dest_pr, disp_told;
	ar_idx_t  disp_dest_ar;
	rob_idx_t disp_rob_idx;
	status_t  disp_kind;

	// ROB back to decode
	logic     rob_full;
	rob_idx_t rob_tail;
	logic     retire_free;
	pr_idx_t  retire_told;

	// Operand reads
	logic     issue_busy;
	pr_idx_t  rd_a, rd_b;
	logic     src_a_ready, src_b_ready;
	data_t    src_a_val, src_b_val;

	// CDB lanes
	logic     cdb0_valid, cdb1_valid;
	pr_idx_t  cdb0_tag, cdb1_tag;
	rob_idx_t cdb0_rob, cdb1_rob;
	data_t    cdb0_val, cdb1_val;

	inst_decode #(.PR_COUNT(PR_COUNT), .ROB_DEPTH(ROB_DEPTH)) u_decode (.*);

	exec_unit #(.PR_COUNT(PR_COUNT)) u_exec (.*);

	phys_regfile #(.PR_COUNT(PR_COUNT)) u_prf (
		.*,
		.alloc_valid(disp_valid),
		.alloc_tag(disp_dest_pr)
	);

	reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_rob (.*);

endmodule

/* bench/tb_clock.sv */
//====================
// Testbench clock and reset
// 100 ns clock, reset held 5 cycles
// Reset repeats on request
//====================
`timescale 1ns/10ps

module tb_clock #(
	parameter int HALF_PERIOD  = 50,
	parameter int RESET_CYCLES = 5
) (
	input  logic reset_req,
	output logic clock,
	output logic rst_n
);
	initial clock = 1'b0;
	always #(HALF_PERIOD) clock = ~clock;

	initial begin
		rst_n = 1'b0;
		forever begin
			repeat (RESET_CYCLES) @(posedge clock);
			@(negedge clock);
			rst_n = 1'b1;	// Release between edges
			@(posedge reset_req);
			@(negedge clock);
			rst_n = 1'b0;
		end
	end

endmodule

/* bench/core_tb.sv */
//====================
// Core testbench
// LFSR stimulus and architectural model
// Commit monitor with compare tasks
// Tests and cycle timeout
//====================
`timescale 1ns/10ps

module core_tb;
	import panda_pkg::*;

	localparam int PR_COUNT    = 64;
	localparam int ROB_DEPTH   = 16;
	localparam int N_ALU       = 60;
	localparam int N_CHAIN     = 40;
	localparam int N_STREAM    = 48;	// Beyond ROB depth and free list
	localparam int N_PRE       = 10;
	localparam int HOLD        = 20;
	localparam int N_INSTS     = N_ALU + 4 + N_CHAIN + N_STREAM + 2 * (N_PRE + 1);
	localparam int CYCLE_LIMIT = 40 * N_INSTS + 200;

	logic       clock;
	logic       rst_n;
	logic       reset_req;
	logic       inst_valid;
	inst_word_t inst;
	logic       stall;
	logic       commit_en;
	ar_idx_t    commit_ar_idx;
	data_t      commit_data;
	status_t    status;

	logic [31:0] lfsr;
	data_t       arch_regs [AR_COUNT];
	ar_idx_t     exp_ar [$];
	data_t       exp_data [$];
	string       test_name;
	int          cycle_count;
	int          stall_cycles;

	tb_clock u_clock (.reset_req(reset_req), .clock(clock), .rst_n(rst_n));

	panda_core #(.PR_COUNT(PR_COUNT), .ROB_DEPTH(ROB_DEPTH)) u_dut (.*);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_ar_idx(input string what, input ar_idx_t exp, input ar_idx_t act);
		if (exp !== act)
			abort_run($sformatf("** Error [%s] %s: expected %0d, actual %0d",
				test_name, what, exp, act));
	endtask

	task automatic check_data(input string what, input data_t exp, input data_t act);
		if (exp !== act)
			abort_run($sformatf("** Error [%s] %s: expected %h, actual %h",
				test_name, what, exp, act));
	endtask

	task automatic check_status(input string what, input status_t exp, input status_t act);
		if (exp !== act)
			abort_run($sformatf("** Error [%s] %s: expected %s, actual %s",
				test_name, what, exp.name(), act.name()));
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (exp !== act)
			abort_run($sformatf("** Error [%s] %s: expected %b, actual %b",
				test_name, what, exp, act));
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic inst_word_t enc_reg(input logic [5:0] op, input ar_idx_t ra,
			input ar_idx_t rb, input func_t fn, input ar_idx_t rc);
		return {op, ra, rb, 3'b000, 1'b0, fn, rc};
	endfunction

	function automatic inst_word_t enc_lit(input logic [5:0] op, input ar_idx_t ra,
			input logic [7:0] lit, input func_t fn, input ar_idx_t rc);
		return {op, ra, lit, 1'b1, fn, rc};
	endfunction

	function automatic func_t rand_func();
		int k;
		k = int'(rand_bits(3) % 6);
		case (k)
			0: return FUNC_ADD;
			1: return FUNC_SUB;
			2: return FUNC_AND;
			3: return FUNC_OR;
			4: return FUNC_XOR;
			default: return FUNC_SLL;
		endcase
	endfunction

	function automatic inst_word_t rand_lit_alu();
		ar_idx_t    ra;
		ar_idx_t    rc;
		logic [7:0] lit;
		func_t      fn;
		ra  = ar_idx_t'(rand_bits(5));
		lit = 8'(rand_bits(8));
		fn  = rand_func();
		rc  = ar_idx_t'(rand_bits(5));
		return enc_lit(OP_INT, ra, lit, fn, rc);
	endfunction

	// Sources and destination from r1..r4 so most ops depend on recent ones
	function automatic inst_word_t rand_dep();
		ar_idx_t    ra;
		ar_idx_t    rb;
		ar_idx_t    rc;
		logic [1:0] kind;
		ra   = ar_idx_t'(1 + rand_bits(2));
		rb   = ar_idx_t'(1 + rand_bits(2));
		rc   = ar_idx_t'(1 + rand_bits(2));
		kind = 2'(rand_bits(2));
		if (kind < 2)
			return enc_reg(OP_MUL, ra, rb, FUNC_MULQ, rc);
		else if (kind == 2)
			return enc_reg(OP_INT, ra, rb, rand_func(), rc);
		else
			return enc_lit(OP_INT, ra, 8'(rand_bits(8)), rand_func(), rc);
	endfunction

	function automatic data_t arch_read(input ar_idx_t r);
		return (r == ZERO_REG) ? '0 : arch_regs[r];
	endfunction

	// Architectural effect of one accepted word
	// Halt and illegal words push nothing
	task automatic model_accept(input inst_word_t w);
		logic [5:0] op;
		func_t      fn;
		ar_idx_t    rc;
		data_t      a;
		data_t      b;
		data_t      res;
		logic       legal;
		op    = w[31:26];
		fn    = w[11:5];
		rc    = w[4:0];
		a     = arch_read(w[25:21]);
		b     = w[12] ? data_t'(w[20:13]) : arch_read(w[20:16]);
		res   = '0;
		legal = 1'b1;
		if (op == OP_MUL && fn == FUNC_MULQ)
			res = a * b;
		else if (op == OP_INT)
			case (fn)
				FUNC_ADD: res = a + b;
				FUNC_SUB: res = a - b;
				FUNC_AND: res = a & b;
				FUNC_OR:  res = a | b;
				FUNC_XOR: res = a ^ b;
				FUNC_SLL: res = a << b[5:0];
				default:  legal = 1'b0;
			endcase
		else
			legal = 1'b0;
		if (legal) begin
			exp_ar.push_back(rc);
			exp_data.push_back(res);
			if (rc != ZERO_REG)
				arch_regs[rc] = res;
		end
	endtask

	// Runs from a falling edge to the falling edge after acceptance
	task automatic send_inst(input inst_word_t w);
		inst_valid = 1'b1;
		inst       = w;
		while (stall) begin
			stall_cycles++;
			@(negedge clock);
		end
		model_accept(w);
		@(negedge clock);
	endtask

	task automatic wait_drain();
		inst_valid = 1'b0;
		while (exp_ar.size() != 0)
			@(negedge clock);
	endtask

	task automatic check_idle();
		check_flag("stall after reset", 1'b0, stall);
		check_flag("commit_en after reset", 1'b0, commit_en);
		check_status("status after reset", running, status);
	endtask

	task automatic reset_dut();
		inst_valid = 1'b0;
		reset_req  = 1'b1;
		@(negedge rst_n);
		reset_req = 1'b0;
		@(posedge rst_n);
		@(negedge clock);
		foreach (arch_regs[i])
			arch_regs[i] = '0;
		check_idle();
	endtask

	task automatic run_stop_test(input inst_word_t stop_word, input status_t exp_status);
		reset_dut();
		for (int i = 0; i < N_PRE; i++)
			send_inst(rand_lit_alu());
		send_inst(stop_word);
		inst_valid = 1'b0;
		while (status == running)
			@(negedge clock);
		check_status("final status", exp_status, status);
		if (exp_ar.size() != 0)
			abort_run($sformatf("[%s] %0d earlier instructions never committed",
				test_name, exp_ar.size()));
		// The core must refuse a valid word now
		inst_valid = 1'b1;
		inst       = rand_lit_alu();
		repeat (HOLD) begin
			check_flag("stall after stop", 1'b1, stall);
			@(negedge clock);
		end
		inst_valid = 1'b0;
	endtask

	always @(negedge clock) begin
		if (rst_n && commit_en) begin
			if (exp_ar.size() == 0) begin
				abort_run($sformatf("[%s] commit seen with no instruction pending", test_name));
			end else begin
				check_ar_idx("commit_ar_idx", exp_ar.pop_front(), commit_ar_idx);
				check_data("commit_data", exp_data.pop_front(), commit_data);
			end
		end
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT)
			abort_run($sformatf("[%s] timeout after %0d cycles", test_name, cycle_count));
	end

	initial begin
		lfsr         = 32'hf1d2;
		inst_valid   = 1'b0;
		inst         = '0;
		reset_req    = 1'b0;
		cycle_count  = 0;
		stall_cycles = 0;
		test_name    = "reset";
		foreach (arch_regs[i])
			arch_regs[i] = '0;
		@(posedge rst_n);
		@(negedge clock);
		check_idle();

		test_name = "literal alu";
		for (int i = 0; i < N_ALU; i++)
			send_inst(rand_lit_alu());
		wait_drain();

		test_name = "mul chains";
		for (int r = 1; r <= 4; r++)
			send_inst(enc_lit(OP_INT, 5'd31, 8'(rand_bits(8) | 1), FUNC_ADD, ar_idx_t'(r)));
		for (int i = 0; i < N_CHAIN; i++)
			send_inst(rand_dep());
		wait_drain();

		test_name    = "long stream";
		stall_cycles = 0;
		for (int i = 0; i < N_STREAM; i++)
			send_inst(rand_dep());
		wait_drain();
		if (stall_cycles == 0)
			abort_run("[long stream] stall never rose while inst_valid was held high");

		test_name = "halt";
		run_stop_test({OP_HALT, 26'(rand_bits(26))}, halted);

		test_name = "illegal opcode";
		run_stop_test({6'h2b, 26'(rand_bits(26))}, illegal_inst);

		$display("NO ERRORS");
		$finish;
	end

endmodule

/* panda_core.f */
hdl/panda_pkg.sv
hdl/inst_decode.sv
hdl/exec_unit.sv
hdl/phys_regfile.sv
hdl/reorder_buffer.sv
hdl/panda_core.sv
bench/tb_clock.sv
bench/core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	--top-module core_tb \
	--Mdir "$OBJ" -o core_tb_sim \
	-f panda_core.f

"./$OBJ/core_tb_sim" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "^NO ERRORS$" "$LOG"; then
	echo "Simulation passed"
else
	echo "Simulation failed, see $LOG"
	exit 1
fi
